/* logic/excp_defs.svh */
`ifndef EXCP_DEFS_SVH
`define EXCP_DEFS_SVH

`define EXCP_XLEN    32
`define EXCP_IS_W    13
`define EXCP_HWI_W   8
`define EXCP_CSR_AW  14
`define EXCP_PGOFS_W 13    // 8 KiB pages, so vppn starts at bit 13

// exception related CSR numbers
`define CSR_CRMD      14'h000
`define CSR_PRMD      14'h001
`define CSR_ECFG      14'h004
`define CSR_ESTAT     14'h005
`define CSR_ERA       14'h006
`define CSR_BADV      14'h007
`define CSR_EENTRY    14'h00c
`define CSR_TLBEHI    14'h011
`define CSR_TLBRENTRY 14'h088

// direct address mode, no paging, kernel level, interrupts masked
`define CRMD_RESET 32'h0000_0008

`endif

/* logic/excp_pkg.sv */
`include "excp_defs.svh"

package excp_pkg;

    typedef enum logic [1:0] {
        KERNEL = 2'd0,
        PLV1   = 2'd1,
        PLV2   = 2'd2,
        USER   = 2'd3
    } plv_t;

    // esubcode in the upper 9 bits and ecode in the lower 6
    typedef enum logic [14:0] {
        INT  = {9'd0, 6'h00},
        PIL  = {9'd0, 6'h01},
        PIS  = {9'd0, 6'h02},
        PIF  = {9'd0, 6'h03},
        PME  = {9'd0, 6'h04},
        PPI  = {9'd0, 6'h07},
        ADEF = {9'd0, 6'h08},
        ADEM = {9'd1, 6'h08},   // same ecode as ADEF, told apart by the subcode
        ALE  = {9'd0, 6'h09},
        SYS  = {9'd0, 6'h0b},
        BRK  = {9'd0, 6'h0c},
        INE  = {9'd0, 6'h0d},
        TLBR = {9'd0, 6'h3f}
    } esubcode_ecode_t;

    typedef struct packed {
        logic [`EXCP_XLEN-6:0] rsvd;
        logic                  pg;
        logic                  da;
        logic                  ie;
        plv_t                  plv;
    } crmd_t;

    typedef struct packed {
        logic [`EXCP_XLEN-4:0] rsvd;
        logic                  pie;
        plv_t                  pplv;
    } prmd_t;

    // BADV keeps the whole address while TLBEHI only wants the page number
    typedef union packed {
        logic [`EXCP_XLEN-1:0] raw;
        struct packed {
            logic [`EXCP_XLEN-`EXCP_PGOFS_W-1:0] vppn;
            logic [`EXCP_PGOFS_W-1:0]            offset;
        } page;
    } badv_u;

endpackage

/* logic/int_pending.sv */
`include "excp_defs.svh"

module int_pending (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ti_in,
    input  logic                   ti_clr,
    input  logic [1:0]             swi_in,
    input  logic [1:0]             swi_clr,
    input  logic [`EXCP_HWI_W-1:0] hwi_in,
    output logic [`EXCP_IS_W-1:0]  int_status
);

    logic       ti_q;
    logic [1:0] swi_q;

    // timer pulse is held until software acknowledges it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ti_q <= 1'b0;
        end else begin
            ti_q <= ~ti_clr & (ti_in | ti_q);   // clear beats a set in the same cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            swi_q <= '0;
        end else begin
            swi_q <= ~swi_clr & (swi_in | swi_q);
        end
    end

    // bit 12 would be the ipi and bit 10 is reserved
    // hardware lines are level sensitive and pass straight through
    assign int_status = {1'b0, ti_q, 1'b0, hwi_in, swi_q};

endmodule

/* logic/excp_commit.sv */
`include "excp_defs.svh"

module excp_commit (
    input  logic                                     req_valid,
    input  logic                                     excp_valid,
    input  excp_pkg::esubcode_ecode_t                ecode,
    input  logic [`EXCP_XLEN-1:0]                    epc,
    input  logic [`EXCP_XLEN-1:0]                    badv,
    input  logic [`EXCP_IS_W-1:0]                    int_status,
    input  excp_pkg::crmd_t                          crmd,
    input  logic [`EXCP_IS_W-1:0]                    ecfg_lie,
    input  logic [`EXCP_XLEN-1:0]                    eentry,
    input  logic [`EXCP_XLEN-1:0]                    tlbrentry,
    output logic                                     flush,
    output logic                                     redirect_valid,
    output logic [`EXCP_XLEN-1:0]                    redirect_pc,
    output logic                                     int_valid,
    output logic                                     upd_we,
    output excp_pkg::crmd_t                          upd_crmd,
    output excp_pkg::prmd_t                          upd_prmd,
    output excp_pkg::esubcode_ecode_t                upd_ecode,
    output logic [`EXCP_XLEN-1:0]                    upd_era,
    output logic                                     upd_badv_we,
    output logic [`EXCP_XLEN-1:0]                    upd_badv,
    output logic                                     upd_tlbehi_we,
    output logic [`EXCP_XLEN-`EXCP_PGOFS_W-1:0]      upd_vppn
);

    import excp_pkg::*;

    logic  take_int;
    logic  take_excp;
    logic  is_tlbr;
    logic  badv_code;
    logic  tlbehi_code;
    badv_u fault_addr;

    assign int_valid = crmd.ie & (|(int_status & ecfg_lie));
    assign take_int  = int_valid & req_valid;   // a bubble in the slot cannot take it
    assign take_excp = excp_valid & ~take_int;  // interrupt wins over the exception
    assign is_tlbr   = take_excp & (ecode == TLBR);

    assign flush          = take_int | take_excp;
    assign redirect_valid = flush;
    assign redirect_pc    = is_tlbr ? tlbrentry : eentry;

    // which codes report a faulting address, and which of those a page number
    always_comb begin
        badv_code   = 1'b0;
        tlbehi_code = 1'b0;
        case (ecode)
            TLBR, PIL, PIS, PIF, PME, PPI: begin
                badv_code   = 1'b1;
                tlbehi_code = 1'b1;
            end
            ADEF, ADEM, ALE: begin
                badv_code = 1'b1;
            end
            default: begin
                badv_code   = 1'b0;
                tlbehi_code = 1'b0;
            end
        endcase
    end

    always_comb begin
        upd_crmd     = crmd;
        upd_crmd.plv = KERNEL;
        upd_crmd.ie  = 1'b0;
        if (is_tlbr) begin
            // refill handler runs untranslated
            upd_crmd.da = 1'b1;
            upd_crmd.pg = 1'b0;
        end
        upd_prmd      = '0;
        upd_prmd.pplv = crmd.plv;
        upd_prmd.pie  = crmd.ie;
    end

    assign fault_addr = badv;

    assign upd_we        = flush;
    assign upd_era       = epc;
    assign upd_ecode     = take_int ? INT : ecode;
    assign upd_badv_we   = take_excp & badv_code;
    assign upd_badv      = fault_addr.raw;
    assign upd_tlbehi_we = take_excp & tlbehi_code;
    assign upd_vppn      = fault_addr.page.vppn;

endmodule

/* logic/excp_csr.sv */
`include "excp_defs.svh"

module excp_csr (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                upd_we,
    input  excp_pkg::crmd_t                     upd_crmd,
    input  excp_pkg::prmd_t                     upd_prmd,
    input  excp_pkg::esubcode_ecode_t           upd_ecode,
    input  logic [`EXCP_XLEN-1:0]               upd_era,
    input  logic                                upd_badv_we,
    input  logic [`EXCP_XLEN-1:0]               upd_badv,
    input  logic                                upd_tlbehi_we,
    input  logic [`EXCP_XLEN-`EXCP_PGOFS_W-1:0] upd_vppn,
    input  logic                                csr_we,
    input  logic [`EXCP_CSR_AW-1:0]             csr_waddr,
    input  logic [`EXCP_XLEN-1:0]               csr_wdata,
    input  logic [`EXCP_CSR_AW-1:0]             csr_raddr,
    output logic [`EXCP_XLEN-1:0]               csr_rdata,
    output excp_pkg::crmd_t                     crmd,
    output excp_pkg::prmd_t                     prmd,
    output logic [`EXCP_IS_W-1:0]               ecfg_lie,
    output logic [`EXCP_XLEN-1:0]               eentry,
    output logic [`EXCP_XLEN-1:0]               tlbrentry
);

    import excp_pkg::*;

    esubcode_ecode_t                     estat_code;
    logic [`EXCP_XLEN-1:0]               era;
    logic [`EXCP_XLEN-1:0]               badv;
    logic [`EXCP_XLEN-`EXCP_PGOFS_W-1:0] tlbehi_vppn;
    logic [`EXCP_XLEN-1:6]               eentry_va;
    logic [`EXCP_XLEN-1:6]               tlbrentry_va;
    badv_u                               tlbehi;

    // a commit update owns these four, so a software write in the same cycle is lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd       <= `CRMD_RESET;
            prmd       <= '0;
            estat_code <= INT;
            era        <= '0;
        end else if (upd_we) begin
            crmd       <= upd_crmd;
            prmd       <= upd_prmd;
            estat_code <= upd_ecode;
            era        <= upd_era;
        end else if (csr_we) begin
            case (csr_waddr)
                `CSR_CRMD: crmd <= '{rsvd: '0, pg: csr_wdata[4], da: csr_wdata[3],
                                     ie: csr_wdata[2], plv: plv_t'(csr_wdata[1:0])};
                `CSR_PRMD: prmd <= '{rsvd: '0, pie: csr_wdata[2],
                                     pplv: plv_t'(csr_wdata[1:0])};
                `CSR_ERA:  era  <= csr_wdata;
                default:   era  <= era;   // ESTAT code is hardware only
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            badv        <= '0;
            tlbehi_vppn <= '0;
        end else begin
            if (upd_badv_we) begin
                badv <= upd_badv;
            end else if (csr_we && csr_waddr == `CSR_BADV) begin
                badv <= csr_wdata;
            end
            if (upd_tlbehi_we) begin
                tlbehi_vppn <= upd_vppn;
            end else if (csr_we && csr_waddr == `CSR_TLBEHI) begin
                tlbehi_vppn <= csr_wdata[`EXCP_XLEN-1:`EXCP_PGOFS_W];
            end
        end
    end

    // entries and interrupt mask only change from software
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eentry_va    <= '0;
            tlbrentry_va <= '0;
            ecfg_lie     <= '0;
        end else if (csr_we) begin
            if (csr_waddr == `CSR_EENTRY)    eentry_va    <= csr_wdata[`EXCP_XLEN-1:6];
            if (csr_waddr == `CSR_TLBRENTRY) tlbrentry_va <= csr_wdata[`EXCP_XLEN-1:6];
            if (csr_waddr == `CSR_ECFG)      ecfg_lie     <= csr_wdata[`EXCP_IS_W-1:0];
        end
    end

    assign eentry    = {eentry_va, 6'b0};
    assign tlbrentry = {tlbrentry_va, 6'b0};

    always_comb begin
        tlbehi.page.vppn   = tlbehi_vppn;
        tlbehi.page.offset = '0;
    end

    always_comb begin
        case (csr_raddr)
            `CSR_CRMD:      csr_rdata = crmd;
            `CSR_PRMD:      csr_rdata = prmd;
            `CSR_ECFG:      csr_rdata = {{(`EXCP_XLEN-`EXCP_IS_W){1'b0}}, ecfg_lie};
            `CSR_ESTAT:     csr_rdata = {1'b0, estat_code, 16'b0};
            `CSR_ERA:       csr_rdata = era;
            `CSR_BADV:      csr_rdata = badv;
            `CSR_EENTRY:    csr_rdata = eentry;
            `CSR_TLBEHI:    csr_rdata = tlbehi.raw;
            `CSR_TLBRENTRY: csr_rdata = tlbrentry;
            default:        csr_rdata = '0;
        endcase
    end

endmodule

/* logic/excp_top.sv */
`include "excp_defs.svh"

module excp_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ti_in,
    input  logic                      ti_clr,
    input  logic [1:0]                swi_in,
    input  logic [1:0]                swi_clr,
    input  logic [`EXCP_HWI_W-1:0]    hwi_in,
    input  logic                      req_valid,
    input  logic                      excp_valid,
    input  excp_pkg::esubcode_ecode_t ecode,
    input  logic [`EXCP_XLEN-1:0]     epc,
    input  logic [`EXCP_XLEN-1:0]     badv,
    input  logic                      csr_we,
    input  logic [`EXCP_CSR_AW-1:0]   csr_waddr,
    input  logic [`EXCP_XLEN-1:0]     csr_wdata,
    input  logic [`EXCP_CSR_AW-1:0]   csr_raddr,
    output logic [`EXCP_XLEN-1:0]     csr_rdata,
    output logic                      flush,
    output logic                      redirect_valid,
    output logic [`EXCP_XLEN-1:0]     redirect_pc,
    output logic                      int_valid,
    output logic [`EXCP_IS_W-1:0]     int_status
);

    import excp_pkg::*;

    crmd_t                               crmd;
    logic [`EXCP_IS_W-1:0]               ecfg_lie;
    logic [`EXCP_XLEN-1:0]               eentry;
    logic [`EXCP_XLEN-1:0]               tlbrentry;
    logic                                upd_we;
    crmd_t                               upd_crmd;
    prmd_t                               upd_prmd;
    esubcode_ecode_t                     upd_ecode;
    logic [`EXCP_XLEN-1:0]               upd_era;
    logic                                upd_badv_we;
    logic [`EXCP_XLEN-1:0]               upd_badv;
    logic                                upd_tlbehi_we;
    logic [`EXCP_XLEN-`EXCP_PGOFS_W-1:0] upd_vppn;

    int_pending u_int_pending (
        .clk        (clk),
        .rst_n      (rst_n),
        .ti_in      (ti_in),
        .ti_clr     (ti_clr),
        .swi_in     (swi_in),
        .swi_clr    (swi_clr),
        .hwi_in     (hwi_in),
        .int_status (int_status)
    );

    excp_commit u_excp_commit (
        .req_valid      (req_valid),
        .excp_valid     (excp_valid),
        .ecode          (ecode),
        .epc            (epc),
        .badv           (badv),
        .int_status     (int_status),
        .crmd           (crmd),
        .ecfg_lie       (ecfg_lie),
        .eentry         (eentry),
        .tlbrentry      (tlbrentry),
        .flush          (flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .int_valid      (int_valid),
        .upd_we         (upd_we),
        .upd_crmd       (upd_crmd),
        .upd_prmd       (upd_prmd),
        .upd_ecode      (upd_ecode),
        .upd_era        (upd_era),
        .upd_badv_we    (upd_badv_we),
        .upd_badv       (upd_badv),
        .upd_tlbehi_we  (upd_tlbehi_we),
        .upd_vppn       (upd_vppn)
    );

    // PRMD is only needed through the read port here
    excp_csr u_excp_csr (
        .clk           (clk),
        .rst_n         (rst_n),
        .upd_we        (upd_we),
        .upd_crmd      (upd_crmd),
        .upd_prmd      (upd_prmd),
        .upd_ecode     (upd_ecode),
        .upd_era       (upd_era),
        .upd_badv_we   (upd_badv_we),
        .upd_badv      (upd_badv),
        .upd_tlbehi_we (upd_tlbehi_we),
        .upd_vppn      (upd_vppn),
        .csr_we        (csr_we),
        .csr_waddr     (csr_waddr),
        .csr_wdata     (csr_wdata),
        .csr_raddr     (csr_raddr),
        .csr_rdata     (csr_rdata),
        .crmd          (crmd),
        .prmd          (),
        .ecfg_lie      (ecfg_lie),
        .eentry        (eentry),
        .tlbrentry     (tlbrentry)
    );

endmodule

/* verif/excp_props.sv */
`include "excp_defs.svh"

module excp_props (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            ti_in,
    input logic                            ti_clr,
    input logic [1:0]                      swi_in,
    input logic [1:0]                      swi_clr,
    input logic [`EXCP_HWI_W-1:0]          hwi_in,
    input logic                            req_valid,
    input logic                            excp_valid,
    input logic [14:0]                     ecode,
    input logic [`EXCP_XLEN-1:0]           epc,
    input logic [`EXCP_XLEN-1:0]           badv,
    input logic                            csr_we,
    input logic [`EXCP_CSR_AW-1:0]         csr_waddr,
    input logic [`EXCP_XLEN-1:0]           csr_wdata,
    input logic [`EXCP_CSR_AW-1:0]         csr_raddr,
    input logic [`EXCP_XLEN-1:0]           csr_rdata,
    input logic                            flush,
    input logic                            redirect_valid,
    input logic [`EXCP_XLEN-1:0]           redirect_pc,
    input logic                            int_valid,
    input logic [`EXCP_IS_W-1:0]           int_status,
    input logic [`EXCP_XLEN-1:0]           crmd
);

    import excp_pkg::*;

    logic                        failed = 1'b0;   // read by the testbench
    logic [`EXCP_XLEN-1:0]       eentry_s;
    logic [`EXCP_XLEN-1:0]       tlbr_s;
    logic [`EXCP_IS_W-1:0]       lie_s;
    logic                        take_int;
    logic                        take_excp;
    logic                        is_tlbr;
    logic                        addr_code;
    logic                        page_code;
    logic                        exp_iv;
    logic [`EXCP_XLEN-1:0]       exp_pc;
    logic                        p_ok;
    logic                        p_flush;
    logic                        p_tlbr;
    logic                        p_bw;
    logic                        p_tw;
    logic                        p_ti;
    logic [1:0]                  p_swi;
    logic [14:0]                 p_code;
    logic [2:0]                  p_crmd;
    logic [`EXCP_XLEN-1:0]       p_epc;
    logic [`EXCP_XLEN-1:0]       p_badv;
    logic [`EXCP_XLEN-1:0]       p_rdata;
    logic [`EXCP_CSR_AW-1:0]     p_raddr;
    logic [`EXCP_XLEN-1:0]       exp_badv;
    logic [`EXCP_XLEN-1:0]       exp_tlbehi;

    // shadow of what software wrote into the entry and mask registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eentry_s <= '0;
            tlbr_s   <= '0;
            lie_s    <= '0;
        end else if (csr_we) begin
            if (csr_waddr == `CSR_EENTRY) eentry_s <= {csr_wdata[31:6], 6'b0};
            if (csr_waddr == `CSR_TLBRENTRY) tlbr_s <= {csr_wdata[31:6], 6'b0};
            if (csr_waddr == `CSR_ECFG) lie_s <= csr_wdata[`EXCP_IS_W-1:0];
        end
    end

    assign exp_iv    = crmd[2] && (|(int_status & lie_s));
    assign take_int  = exp_iv && req_valid;
    assign take_excp = excp_valid && !take_int;
    assign is_tlbr   = take_excp && (ecode == TLBR);
    assign addr_code = ecode inside {TLBR, PIL, PIS, PIF, PME, PPI, ADEF, ADEM, ALE};
    assign page_code = ecode inside {TLBR, PIL, PIS, PIF, PME, PPI};
    assign exp_pc    = is_tlbr ? tlbr_s : eentry_s;

    always_ff @(posedge clk) begin
        p_ok    <= rst_n;
        p_flush <= take_int || take_excp;
        p_tlbr  <= is_tlbr;
        p_bw    <= take_excp && addr_code;
        p_tw    <= take_excp && page_code;
        p_ti    <= !ti_clr && (ti_in || int_status[11]);   // clear wins over set
        p_swi   <= ~swi_clr & (swi_in | int_status[1:0]);
        p_code  <= take_int ? 15'(INT) : ecode;
        p_crmd  <= crmd[2:0];
        p_epc   <= epc;
        p_badv  <= badv;
        p_rdata <= csr_rdata;
        p_raddr <= csr_raddr;
    end

    assign exp_badv   = p_bw ? p_badv : p_rdata;
    assign exp_tlbehi = p_tw ? {p_badv[31:13], 13'b0} : p_rdata;

    a_rst_out: assert property (@(posedge clk) !rst_n |-> !flush && !redirect_valid && !int_valid)
        else begin $error("[ERROR] %0t flush/redirect_valid/int_valid exp=000 got=%b%b%b",
            $time, flush, redirect_valid, int_valid); failed = 1'b1; end
    a_rst_crmd: assert property (@(posedge clk)
        !rst_n && csr_raddr == `CSR_CRMD |=> csr_rdata == `CRMD_RESET)
        else begin $error("[ERROR] %0t crmd exp=%0h got=%0h", $time, `CRMD_RESET, csr_rdata);
            failed = 1'b1; end
    a_rst_is: assert property (@(posedge clk) !rst_n |=> int_status == '0)
        else begin $error("[ERROR] %0t int_status exp=0 got=%0h", $time, int_status);
            failed = 1'b1; end
    a_latch: assert property (@(posedge clk) rst_n && p_ok |->
        int_status[11] == p_ti && int_status[1:0] == p_swi)
        else begin $error("[ERROR] %0t int_status exp=%0h got=%0h", $time, {p_ti, p_swi},
            {int_status[11], int_status[1:0]}); failed = 1'b1; end
    a_hwi: assert property (@(posedge clk)
        int_status[9:2] == hwi_in && !int_status[12] && !int_status[10])
        else begin $error("[ERROR] %0t int_status exp=%0h got=%0h", $time,
            {1'b0, int_status[11], 1'b0, hwi_in, int_status[1:0]}, int_status);
            failed = 1'b1; end
    a_intv: assert property (@(posedge clk) disable iff (!rst_n) int_valid == exp_iv)
        else begin $error("[ERROR] %0t int_valid exp=%0h got=%0h", $time, exp_iv, int_valid);
            failed = 1'b1; end
    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush == (take_int || take_excp) && redirect_valid == flush)
        else begin $error("[ERROR] %0t flush/redirect_valid exp=%b%b got=%b%b", $time,
            take_int || take_excp, take_int || take_excp, flush, redirect_valid);
            failed = 1'b1; end
    a_pc: assert property (@(posedge clk) disable iff (!rst_n) flush |-> redirect_pc == exp_pc)
        else begin $error("[ERROR] %0t redirect_pc exp=%0h got=%0h", $time, exp_pc,
            redirect_pc); failed = 1'b1; end
    a_era: assert property (@(posedge clk) disable iff (!rst_n)
        p_flush && csr_raddr == `CSR_ERA |-> csr_rdata == p_epc)
        else begin $error("[ERROR] %0t era exp=%0h got=%0h", $time, p_epc, csr_rdata);
            failed = 1'b1; end
    a_estat: assert property (@(posedge clk) disable iff (!rst_n)
        p_flush && csr_raddr == `CSR_ESTAT |-> csr_rdata[30:16] == p_code)
        else begin $error("[ERROR] %0t estat exp=%0h got=%0h", $time, p_code,
            csr_rdata[30:16]); failed = 1'b1; end
    a_crmd: assert property (@(posedge clk) disable iff (!rst_n)
        p_flush && csr_raddr == `CSR_CRMD |->
        csr_rdata[2:0] == 3'b0 && (!p_tlbr || csr_rdata[4:3] == 2'b01))
        else begin $error("[ERROR] %0t crmd exp=%0h got=%0h", $time, p_tlbr ? 5'h08 : 5'h0,
            csr_rdata[4:0]); failed = 1'b1; end
    a_prmd: assert property (@(posedge clk) disable iff (!rst_n)
        p_flush && csr_raddr == `CSR_PRMD |-> csr_rdata[2:0] == p_crmd)
        else begin $error("[ERROR] %0t prmd exp=%0h got=%0h", $time, p_crmd, csr_rdata[2:0]);
            failed = 1'b1; end
    a_badv: assert property (@(posedge clk) disable iff (!rst_n)
        p_ok && csr_raddr == p_raddr && csr_raddr == `CSR_BADV |-> csr_rdata == exp_badv)
        else begin $error("[ERROR] %0t badv exp=%0h got=%0h", $time, exp_badv, csr_rdata);
            failed = 1'b1; end
    a_tlbehi: assert property (@(posedge clk) disable iff (!rst_n)
        p_ok && csr_raddr == p_raddr && csr_raddr == `CSR_TLBEHI |-> csr_rdata == exp_tlbehi)
        else begin $error("[ERROR] %0t tlbehi exp=%0h got=%0h", $time, exp_tlbehi, csr_rdata);
            failed = 1'b1; end

endmodule

bind excp_top excp_props u_excp_props (.*);

/* verif/excp_tb.sv */
`include "excp_defs.svh"

module excp_tb;

    import excp_pkg::*;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   ti_in;
    logic                   ti_clr;
    logic [1:0]             swi_in;
    logic [1:0]             swi_clr;
    logic [`EXCP_HWI_W-1:0] hwi_in;
    logic                   req_valid;
    logic                   excp_valid;
    esubcode_ecode_t        ecode;
    logic [`EXCP_XLEN-1:0]  epc;
    logic [`EXCP_XLEN-1:0]  badv;
    logic                   csr_we;
    logic [`EXCP_CSR_AW-1:0] csr_waddr;
    logic [`EXCP_XLEN-1:0]  csr_wdata;
    logic [`EXCP_CSR_AW-1:0] csr_raddr;
    logic [`EXCP_XLEN-1:0]  csr_rdata;
    logic                   flush;
    logic                   redirect_valid;
    logic [`EXCP_XLEN-1:0]  redirect_pc;
    logic                   int_valid;
    logic [`EXCP_IS_W-1:0]  int_status;
    int                     cycles = 0;
    esubcode_ecode_t        codes [12] = '{PIL, PIS, PIF, PME, PPI, ADEF, ADEM, ALE,
                                           SYS, BRK, INE, TLBR};
    logic [`EXCP_CSR_AW-1:0] views [4] = '{`CSR_BADV, `CSR_TLBEHI, `CSR_ESTAT, `CSR_CRMD};
    logic [`EXCP_CSR_AW-1:0] int_views [4] = '{`CSR_ERA, `CSR_ESTAT, `CSR_CRMD, `CSR_PRMD};

    excp_top u_excp_top (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display("ERRORS FOUND");
            $fatal(1, "timeout, the stimulus did not finish within 2000 cycles");
        end
    end

    always @(posedge clk) begin
        if (u_excp_top.u_excp_props.failed) begin
            $display("ERRORS FOUND");
            $fatal(1, "an assertion on the DUT outputs failed");
        end
    end

    // strobes last one cycle unless the caller sets them again
    task automatic next_cycle();
        @(posedge clk);
        #2;
        ti_in      = 1'b0;
        ti_clr     = 1'b0;
        swi_in     = '0;
        swi_clr    = '0;
        req_valid  = 1'b0;
        excp_valid = 1'b0;
        csr_we     = 1'b0;
    endtask

    task automatic write_csr(input logic [`EXCP_CSR_AW-1:0] addr, input logic [31:0] data);
        next_cycle();
        csr_we    = 1'b1;
        csr_waddr = addr;
        csr_wdata = data;
    endtask

    task automatic commit_slot(input logic req, input logic excp, input esubcode_ecode_t code);
        next_cycle();
        req_valid  = req;
        excp_valid = excp;
        ecode      = code;
        epc        = $urandom;
        badv       = $urandom;
    endtask

    initial begin
        logic [31:0] r;
        r = $urandom(50889);
        rst_n = 1'b0;
        {ti_in, ti_clr, swi_in, swi_clr, hwi_in} = '0;
        {req_valid, excp_valid, csr_we, csr_waddr, csr_wdata} = '0;
        ecode     = INT;
        epc       = '0;
        badv      = '0;
        csr_raddr = `CSR_CRMD;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
        next_cycle();
        write_csr(`CSR_EENTRY, $urandom);
        write_csr(`CSR_TLBRENTRY, $urandom);
        r = $urandom;
        write_csr(`CSR_ECFG, {19'b0, r[12:0]});
        // random pulses on the pending lines, first masked and then enabled
        for (int i = 0; i < 80; i++) begin
            if (i == 40) write_csr(`CSR_CRMD, 32'h0000_0007);
            next_cycle();
            r       = $urandom;
            ti_in   = r[0];
            ti_clr  = r[1] & r[2];
            swi_in  = r[4:3];
            swi_clr = r[6:5] & r[8:7];
            hwi_in  = r[16:9];
        end
        write_csr(`CSR_ECFG, 32'h0000_1fff);
        hwi_in = 8'h01;
        for (int v = 0; v < 4; v++) begin
            csr_raddr = int_views[v];
            r = $urandom;
            write_csr(`CSR_CRMD, {29'b0, 1'b1, r[1:0]});
            commit_slot(1'b0, 1'b0, INT);
            commit_slot(1'b1, 1'b0, INT);
            next_cycle();
        end
        // both in one slot, the interrupt has to win
        csr_raddr = `CSR_BADV;
        write_csr(`CSR_CRMD, 32'h0000_0007);
        commit_slot(1'b1, 1'b1, ADEF);
        next_cycle();
        csr_raddr = `CSR_ESTAT;
        write_csr(`CSR_CRMD, 32'h0000_0007);
        commit_slot(1'b1, 1'b1, PIL);
        next_cycle();
        hwi_in = '0;
        for (int v = 0; v < 4; v++) begin
            csr_raddr = views[v];
            for (int i = 0; i < 40; i++) begin
                r = $urandom;
                commit_slot(r[4], 1'b1, codes[r[31:8] % 12]);
                next_cycle();
            end
        end
        repeat (3) next_cycle();
        if (u_excp_top.u_excp_props.failed) begin
            $display("ERRORS FOUND");
            $fatal(1, "an assertion on the DUT outputs failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+logic
logic/excp_pkg.sv
logic/int_pending.sv
logic/excp_commit.sv
logic/excp_csr.sv
logic/excp_top.sv
verif/excp_props.sv
verif/excp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exception commit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module excp_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# let assertion errors reach the testbench instead of stopping on the first one
./obj_dir/Vexcp_tb +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
